//--- msp430_bcm_fpga.f
verilog/bcm_reg_pkg.sv
verilog/bcm_clk_pkg.sv
verilog/bcm_regs.sv
verilog/bcm_clk_sources.sv
verilog/bcm_clk_divider.sv
verilog/bcm_fpga.sv
testbench/bcm_assertions.sv
testbench/bcm_checker.sv
testbench/tb_bcm_fpga.sv

//--- testbench/tb_bcm_fpga.sv
// Testbench for the basic clock module registers and clock enable generator
module tb_bcm_fpga;

  timeunit 1ns;
  timeprecision 1ps;

  import bcm_reg_pkg::*;

  localparam int SETTLE   = 16;
  localparam int WAIT_MAX = 64;
  localparam int NROWS    = 12;

  // Byte addresses, word address drops the lane bit
  localparam logic [15:0] BCSCTL1_BA = BASE_ADDR + {12'h000, BCSCTL1_OFS};
  localparam logic [15:0] BCSCTL2_BA = BASE_ADDR + {12'h000, BCSCTL2_OFS};
  localparam logic [PER_AW-1:0] BCSCTL1_WA = BCSCTL1_BA[PER_AW:1];
  localparam logic [PER_AW-1:0] BCSCTL2_WA = BCSCTL2_BA[PER_AW:1];
  localparam logic [PER_AW-1:0] OUT_WA     = BCSCTL1_WA + 14'h0008;  // next block up

  typedef struct {
    string      name;
    logic [7:0] bcsctl1;
    logic [7:0] bcsctl2;
    logic       oscoff;
    logic       scg1;
    logic       cpu_en;
    int         half;
    int         window;
    logic [7:0] rd1;
    logic [7:0] rd2;
    int         exp_aclk;
    int         exp_smclk;
  } row_t;

  logic        mclk, puc_rst, cpu_en, lfxt_clk, oscoff, scg1;
  per_req_t    per;
  logic [15:0] per_dout;
  logic        aclk_en, smclk_en;
  logic        rd_chk, cnt_go, cnt_done;
  logic [15:0] rd_exp;
  int          cnt_win, exp_aclk, exp_smclk, chk_cnt, err_cnt;
  int          lfxt_half, lfxt_cnt;
  row_t        rows [NROWS];

  bcm_fpga i_bcm_fpga (.mclk(mclk), .puc_rst(puc_rst), .cpu_en(cpu_en), .lfxt_clk(lfxt_clk),
    .oscoff(oscoff), .scg1(scg1), .per(per), .per_dout(per_dout), .aclk_en(aclk_en),
    .smclk_en(smclk_en));

  bcm_checker u_checker (.mclk(mclk), .per_dout(per_dout), .aclk_en(aclk_en),
    .smclk_en(smclk_en), .rd_chk(rd_chk), .rd_exp(rd_exp), .cnt_go(cnt_go), .cnt_win(cnt_win),
    .exp_aclk(exp_aclk), .exp_smclk(exp_smclk), .cnt_done(cnt_done), .chk_cnt(chk_cnt),
    .err_cnt(err_cnt));

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  // Crystal model, toggles every lfxt_half mclk cycles
  always @(posedge mclk) begin
    if (lfxt_cnt >= lfxt_half - 1) begin
      lfxt_cnt <= 0;
      lfxt_clk <= ~lfxt_clk;
    end else begin
      lfxt_cnt <= lfxt_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////

  task automatic bus_write(input logic [PER_AW-1:0] addr, input logic [1:0] we,
                           input logic [15:0] din);
    per <= '{en: 1'b1, addr: addr, we: we, din: din};
    @(posedge mclk);
    per <= '0;
  endtask

  // One byte on its lane
  task automatic write_reg(input logic [PER_AW-1:0] addr, input logic hi, input logic [7:0] val);
    bus_write(addr, hi ? 2'b10 : 2'b01, hi ? {val, 8'h00} : {8'h00, val});
  endtask

  // Expected word holds the byte on its lane, zero elsewhere
  task automatic read_reg(input logic [PER_AW-1:0] addr, input logic hi, input logic [7:0] val);
    per_word_u exp_w;
    exp_w.raw = 16'h0000;
    if (hi)
      exp_w.b.hi = val;
    else
      exp_w.b.lo = val;
    per <= '{en: 1'b1, addr: addr, we: 2'b00, din: 16'h0000};
    rd_chk <= 1'b1;
    rd_exp <= exp_w.raw;
    @(posedge mclk);
    per <= '0;
    rd_chk <= 1'b0;
  endtask

  // Hand a window to the checker and wait for its result
  task automatic count_window(input string name, input int win, input int ea, input int es);
    int t;
    cnt_win <= win;
    exp_aclk <= ea;
    exp_smclk <= es;
    cnt_go <= 1'b1;
    @(posedge mclk);
    cnt_go <= 1'b0;
    @(posedge mclk);
    t = 0;
    while (!cnt_done && t < win + WAIT_MAX) begin
      @(posedge mclk);
      t = t + 1;
    end
    if (!cnt_done) begin
      $display("Timeout: pulse count window of %s never completed", name);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int i;
    puc_rst = 1'b1;
    cpu_en = 1'b0;
    lfxt_clk = 1'b0;
    oscoff = 1'b0;
    scg1 = 1'b0;
    per = '0;
    rd_chk = 1'b0;
    rd_exp = 16'h0000;
    cnt_go = 1'b0;
    cnt_win = 0;
    exp_aclk = 0;
    exp_smclk = 0;
    lfxt_half = 2;
    lfxt_cnt = 0;
    // name, BCSCTL1, BCSCTL2, oscoff, scg1, cpu_en, half, window, reads, aclk, smclk
    rows[0]  = '{"smclk_div1",   8'h00, 8'h00, 0, 0, 1, 2, 256, 8'h00, 8'h00, 64, 256};
    rows[1]  = '{"smclk_div2",   8'h10, 8'h02, 0, 0, 1, 2, 256, 8'h10, 8'h02, 32, 128};
    rows[2]  = '{"smclk_div4",   8'h20, 8'h04, 0, 0, 1, 2, 256, 8'h20, 8'h04, 16, 64};
    rows[3]  = '{"smclk_div8",   8'hFF, 8'hF7, 0, 0, 1, 2, 256, 8'h30, 8'h06, 8, 32};
    rows[4]  = '{"lfxt_div1",    8'h00, 8'h08, 0, 0, 1, 2, 256, 8'h00, 8'h08, 64, 64};
    rows[5]  = '{"lfxt_div2",    8'h30, 8'h0A, 0, 0, 1, 2, 256, 8'h30, 8'h0A, 8, 32};
    rows[6]  = '{"lfxt_div4",    8'h10, 8'h0C, 0, 0, 1, 2, 256, 8'h10, 8'h0C, 32, 16};
    rows[7]  = '{"lfxt_div8",    8'h20, 8'h0E, 0, 0, 1, 2, 256, 8'h20, 8'h0E, 16, 8};
    rows[8]  = '{"oscoff_sels0", 8'h00, 8'h02, 1, 0, 1, 2, 256, 8'h00, 8'h02, 0, 128};
    rows[9]  = '{"oscoff_sels1", 8'h10, 8'h08, 1, 0, 1, 2, 256, 8'h10, 8'h08, 32, 64};
    rows[10] = '{"scg1_off",     8'h10, 8'h08, 0, 1, 1, 2, 256, 8'h10, 8'h08, 32, 0};
    rows[11] = '{"cpu_off",      8'h00, 8'h00, 0, 0, 0, 2, 256, 8'h00, 8'h00, 0, 0};
    repeat (4) @(posedge mclk);
    puc_rst <= 1'b0;
    @(posedge mclk);
    // Out of reset, cpu_en still low
    u_checker.set_test("reset");
    read_reg(BCSCTL1_WA, BCSCTL1_OFS[0], 8'h00);
    read_reg(BCSCTL2_WA, BCSCTL2_OFS[0], 8'h00);
    count_window("reset", 128, 0, 0);
    // Masking, wrong lane and foreign address
    u_checker.set_test("bus_access");
    write_reg(BCSCTL1_WA, BCSCTL1_OFS[0], 8'hFF);
    write_reg(BCSCTL2_WA, BCSCTL2_OFS[0], 8'hFF);
    read_reg(BCSCTL1_WA, BCSCTL1_OFS[0], 8'h30);
    read_reg(BCSCTL2_WA, BCSCTL2_OFS[0], 8'h0E);
    write_reg(BCSCTL1_WA, !BCSCTL1_OFS[0], 8'h00);
    write_reg(BCSCTL2_WA, !BCSCTL2_OFS[0], 8'h00);
    bus_write(OUT_WA, 2'b11, 16'h0000);
    read_reg(BCSCTL1_WA, BCSCTL1_OFS[0], 8'h30);
    read_reg(BCSCTL2_WA, BCSCTL2_OFS[0], 8'h0E);
    read_reg(OUT_WA, 1'b1, 8'h00);
    for (i = 0; i < NROWS; i++) begin
      u_checker.set_test(rows[i].name);
      lfxt_half <= rows[i].half;
      oscoff <= rows[i].oscoff;
      scg1 <= rows[i].scg1;
      cpu_en <= rows[i].cpu_en;
      write_reg(BCSCTL1_WA, BCSCTL1_OFS[0], rows[i].bcsctl1);
      write_reg(BCSCTL2_WA, BCSCTL2_OFS[0], rows[i].bcsctl2);
      read_reg(BCSCTL1_WA, BCSCTL1_OFS[0], rows[i].rd1);
      read_reg(BCSCTL2_WA, BCSCTL2_OFS[0], rows[i].rd2);
      repeat (SETTLE) @(posedge mclk);
      count_window(rows[i].name, rows[i].window, rows[i].exp_aclk, rows[i].exp_smclk);
    end
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             chk_cnt, err_cnt, i_bcm_fpga.u_assertions.fail_cnt);
    if (err_cnt == 0 && i_bcm_fpga.u_assertions.fail_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- testbench/bcm_checker.sv
// Testbench checker comparing bus read data and counting clock enable pulses
module bcm_checker (
  input  logic                  mclk,
  input  logic [15:0]           per_dout,
  input  logic                  aclk_en,
  input  logic                  smclk_en,
  input  logic                  rd_chk,
  input  logic [15:0]           rd_exp,
  input  logic                  cnt_go,
  input  int                    cnt_win,
  input  int                    exp_aclk,
  input  int                    exp_smclk,
  output logic                  cnt_done,
  output int                    chk_cnt,
  output int                    err_cnt
);

  timeunit 1ns;
  timeprecision 1ps;

  import bcm_reg_pkg::*;

  string     test_name;
  per_word_u rd_word;
  logic      cnt_busy;
  int        cnt_left;
  int        aclk_cnt;
  int        smclk_cnt;

  initial begin
    test_name = "none";
    cnt_busy  = 1'b0;
    cnt_done  = 1'b0;
    chk_cnt   = 0;
    err_cnt   = 0;
  end

  // Name shown in report lines
  task automatic set_test(input string name);
    test_name = name;
  endtask

  ////////////////////////////////////////
  // Read data and pulse windows
  ////////////////////////////////////////

  always @(posedge mclk) begin
    // Read data is combinational in the strobe cycle
    if (rd_chk) begin
      chk_cnt = chk_cnt + 1;
      rd_word.raw = per_dout;
      if (rd_word.raw !== rd_exp) begin
        err_cnt = err_cnt + 1;
        $display("FAIL %s read: expected %04h, actual %04h (hi %02h lo %02h)",
                 test_name, rd_exp, rd_word.raw, rd_word.b.hi, rd_word.b.lo);
      end
    end else if (per_dout !== 16'h0000) begin
      // No read strobe, data bus stays at zero
      err_cnt = err_cnt + 1;
      $display("FAIL %s idle per_dout: expected 0000, actual %04h", test_name, per_dout);
    end
    // Pulse counting, one sample per mclk
    if (cnt_busy) begin
      aclk_cnt  = aclk_cnt + aclk_en;
      smclk_cnt = smclk_cnt + smclk_en;
      cnt_left  = cnt_left - 1;
      if (cnt_left == 0) begin
        cnt_busy = 1'b0;
        chk_cnt  = chk_cnt + 2;
        if (aclk_cnt != exp_aclk) begin
          err_cnt = err_cnt + 1;
          $display("FAIL %s aclk_en pulses: expected %0d, actual %0d",
                   test_name, exp_aclk, aclk_cnt);
        end
        if (smclk_cnt != exp_smclk) begin
          err_cnt = err_cnt + 1;
          $display("FAIL %s smclk_en pulses: expected %0d, actual %0d",
                   test_name, exp_smclk, smclk_cnt);
        end
        cnt_done <= 1'b1;
      end
    end else if (cnt_go) begin
      aclk_cnt  = 0;
      smclk_cnt = 0;
      cnt_left  = cnt_win;
      cnt_busy  = 1'b1;
      cnt_done <= 1'b0;
    end
  end

endmodule

//--- testbench/bcm_assertions.sv
// Basic clock module bound assertions on clock enables and BCSCTL1 read-back
module bcm_assertions (
  input  logic                  mclk,
  input  logic                  puc_rst,
  input  logic                  cpu_en,
  input  logic                  scg1,
  input  bcm_reg_pkg::per_req_t per,
  input  logic [15:0]           per_dout,
  input  logic                  aclk_en,
  input  logic                  smclk_en
);

  timeunit 1ns;
  timeprecision 1ps;

  import bcm_reg_pkg::*;

  // BCSCTL1 byte address, its word address drops the lane bit
  localparam logic [15:0] BCSCTL1_BA = BASE_ADDR + {12'h000, BCSCTL1_OFS};

  logic bcsctl1_read;

  // Failed assertions so far
  int   fail_cnt = 0;

  assign bcsctl1_read = per.en & (per.we == 2'b00) & (per.addr == BCSCTL1_BA[PER_AW:1]);

  // CPU stopped, both enables drop one cycle later
  a_cpu_off: assert property (@(posedge mclk) disable iff (puc_rst)
    !cpu_en |=> (!aclk_en && !smclk_en))
    else begin
      fail_cnt++;
      $error("clock enable pulse after cpu_en was low");
    end

  // SMCLK switched off
  a_scg1_off: assert property (@(posedge mclk) disable iff (puc_rst)
    scg1 ##1 scg1 |=> !smclk_en)
    else begin
      fail_cnt++;
      $error("smclk_en pulse while scg1 was high");
    end

  // Only DIVAx may read back, BCSCTL1 lives in the high lane
  a_bcsctl1_mask: assert property (@(posedge mclk) disable iff (puc_rst)
    bcsctl1_read |-> ((per_dout[15:8] & ~BCSCTL1_MASK) == 8'h00))
    else begin
      fail_cnt++;
      $error("BCSCTL1 read shows bits outside its mask");
    end

endmodule

bind bcm_fpga bcm_assertions u_assertions (
  .mclk     (mclk),
  .puc_rst  (puc_rst),
  .cpu_en   (cpu_en),
  .scg1     (scg1),
  .per      (per),
  .per_dout (per_dout),
  .aclk_en  (aclk_en),
  .smclk_en (smclk_en)
);

//--- verilog/bcm_fpga.sv
// Basic clock module top level for single-clock FPGA builds
module bcm_fpga (
  input  logic                  mclk,
  input  logic                  puc_rst,
  input  logic                  cpu_en,
  input  logic                  lfxt_clk,
  input  logic                  oscoff,
  input  logic                  scg1,
  input  bcm_reg_pkg::per_req_t per,
  output logic [15:0]           per_dout,
  output logic                  aclk_en,
  output logic                  smclk_en
);

  import bcm_clk_pkg::*;

  // Register fields for the clock logic
  clk_cfg_t cfg;

  // Source ticks, one mclk wide
  logic     lfxt_tick;
  logic     smclk_tick;

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  bcm_regs u_regs (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per      (per),
    .per_dout (per_dout),
    .cfg      (cfg)
  );

  ////////////////////////////////////////
  // Clock sources
  ////////////////////////////////////////

  bcm_clk_sources u_sources (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .lfxt_clk   (lfxt_clk),
    .oscoff     (oscoff),
    .scg1       (scg1),
    .cfg        (cfg),
    .lfxt_tick  (lfxt_tick),
    .smclk_tick (smclk_tick)
  );

  ////////////////////////////////////////
  // Dividers
  ////////////////////////////////////////

  // ACLK always runs from the crystal
  bcm_clk_divider u_aclk_div (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .tick    (lfxt_tick),
    .cpu_en  (cpu_en),
    .div_sel (cfg.diva),
    .clk_en  (aclk_en)
  );

  // SMCLK source already chosen and gated
  bcm_clk_divider u_smclk_div (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .tick    (smclk_tick),
    .cpu_en  (cpu_en),
    .div_sel (cfg.divs),
    .clk_en  (smclk_en)
  );

endmodule

//--- verilog/bcm_clk_divider.sv
// Basic clock module prescaler turning source ticks into a divided clock enable
module bcm_clk_divider (
  input  logic                  mclk,
  input  logic                  puc_rst,
  input  logic                  tick,
  input  logic                  cpu_en,
  input  bcm_clk_pkg::div_sel_t div_sel,
  output logic                  clk_en
);

  import bcm_clk_pkg::*;

  logic [DIV_CW-1:0] div_cnt;
  logic              cnt_full;
  logic              clk_en_nxt;

  ////////////////////////////////////////
  // Prescaler counter
  ////////////////////////////////////////

  // Counts source ticks, parked when not dividing
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      div_cnt <= '0;
    end else if (tick && (div_sel != DIV_1)) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Low N bits all ones for divide by 2^N
  always_comb begin
    case (div_sel)
      DIV_1:   cnt_full = 1'b1;
      DIV_2:   cnt_full = div_cnt[0];
      DIV_4:   cnt_full = &div_cnt[1:0];
      default: cnt_full = &div_cnt;  // DIV_8
    endcase
  end

  ////////////////////////////////////////
  // Enable output
  ////////////////////////////////////////

  // Tick that closes a division period
  assign clk_en_nxt = tick & cnt_full;

  // Registered pulse
  // cpu_en already synchronous to mclk
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      clk_en <= 1'b0;
    end else begin
      clk_en <= clk_en_nxt & cpu_en;
    end
  end

endmodule

//--- verilog/bcm_clk_sources.sv
// Basic clock module crystal synchronizer, edge detector and ACLK/SMCLK tick sources
module bcm_clk_sources (
  input  logic                  mclk,
  input  logic                  puc_rst,
  input  logic                  lfxt_clk,
  input  logic                  oscoff,
  input  logic                  scg1,
  input  bcm_clk_pkg::clk_cfg_t cfg,
  output logic                  lfxt_tick,
  output logic                  smclk_tick
);

  // Two-flop synchronizer, bit 1 is the safe copy
  logic [1:0] lfxt_sync;

  // Previous synchronized level
  logic       lfxt_dly;

  logic       lfxt_rise;
  logic       lfxt_stop;

  ////////////////////////////////////////
  // Crystal edge detection
  ////////////////////////////////////////

  // Bring the slow crystal into mclk
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      lfxt_sync <= 2'b00;
    end else begin
      lfxt_sync <= {lfxt_sync[0], lfxt_clk};
    end
  end

  // Delay stage for the edge compare
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      lfxt_dly <= 1'b0;
    end else begin
      lfxt_dly <= lfxt_sync[1];
    end
  end

  // One mclk pulse per crystal rising edge
  assign lfxt_rise = lfxt_sync[1] & ~lfxt_dly;

  // Oscillator off only matters when SMCLK does not run from it
  assign lfxt_stop = oscoff & ~cfg.sels;

  assign lfxt_tick = lfxt_rise & ~lfxt_stop;

  ////////////////////////////////////////
  // SMCLK source
  ////////////////////////////////////////

  // Crystal edges or every mclk cycle
  // scg1 switches the source off
  assign smclk_tick = ~scg1 & (cfg.sels ? lfxt_tick : 1'b1);

endmodule

//--- verilog/bcm_regs.sv
// Basic clock module BCSCTL1/BCSCTL2 bus decoder, masked registers and read mux
module bcm_regs (
  input  logic                  mclk,
  input  logic                  puc_rst,
  input  bcm_reg_pkg::per_req_t per,
  output logic [15:0]           per_dout,
  output bcm_clk_pkg::clk_cfg_t cfg
);

  import bcm_reg_pkg::*;

  // Decoder
  logic              reg_sel;
  logic [DEC_WD-1:0] reg_addr;
  logic              reg_read;
  logic              hit_bcsctl1;
  logic              hit_bcsctl2;

  // Write path
  per_word_u         wr_word;
  logic              bcsctl1_wr;
  logic              bcsctl2_wr;
  logic [7:0]        bcsctl1_nxt;
  logic [7:0]        bcsctl2_nxt;

  // Registers
  logic [7:0]        bcsctl1;
  logic [7:0]        bcsctl2;

  // Read path
  logic              bcsctl1_rd;
  logic              bcsctl2_rd;
  per_word_u         rd_word;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Block select on the upper word address bits
  assign reg_sel = per.en & (per.addr[PER_AW-1:DEC_WD-1] == BASE_ADDR[PER_AW:DEC_WD]);

  // Local word address inside the block
  assign reg_addr = {1'b0, per.addr[DEC_WD-2:0]};

  // Word hits, offsets are bytes so drop the lane bit
  assign hit_bcsctl1 = reg_sel & (reg_addr == (BCSCTL1_OFS >> 1));
  assign hit_bcsctl2 = reg_sel & (reg_addr == (BCSCTL2_OFS >> 1));

  // No write enable at all is a read
  assign reg_read = ~|per.we;

  // Byte strobes, each register only on its own lane
  assign bcsctl1_wr = hit_bcsctl1 & (BCSCTL1_OFS[0] ? per.we[1] : per.we[0]);
  assign bcsctl2_wr = hit_bcsctl2 & (BCSCTL2_OFS[0] ? per.we[1] : per.we[0]);

  assign bcsctl1_rd = hit_bcsctl1 & reg_read;
  assign bcsctl2_rd = hit_bcsctl2 & reg_read;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // Split incoming word into lanes
  assign wr_word.raw = per.din;

  assign bcsctl1_nxt = BCSCTL1_OFS[0] ? wr_word.b.hi : wr_word.b.lo;
  assign bcsctl2_nxt = BCSCTL2_OFS[0] ? wr_word.b.hi : wr_word.b.lo;

  // BCSCTL1, only DIVAx is kept
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bcsctl1 <= 8'h00;
    end else if (bcsctl1_wr) begin
      bcsctl1 <= bcsctl1_nxt & BCSCTL1_MASK;
    end
  end

  // BCSCTL2, SELS and DIVSx
  // MCLK fields are not implemented
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bcsctl2 <= 8'h00;
    end else if (bcsctl2_wr) begin
      bcsctl2 <= bcsctl2_nxt & BCSCTL2_MASK;
    end
  end

  ////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////

  // Selected register in its lane, zero elsewhere
  always_comb begin
    rd_word.raw = 16'h0000;
    if (bcsctl1_rd) begin
      if (BCSCTL1_OFS[0]) begin
        rd_word.b.hi = bcsctl1;
      end else begin
        rd_word.b.lo = bcsctl1;
      end
    end
    if (bcsctl2_rd) begin
      if (BCSCTL2_OFS[0]) begin
        rd_word.b.hi = bcsctl2;
      end else begin
        rd_word.b.lo = bcsctl2;
      end
    end
  end

  assign per_dout = rd_word.raw;

  // Fields handed to the clock logic
  assign cfg = '{
    diva: bcsctl1[DIVA_LSB +: 2],
    divs: bcsctl2[DIVS_LSB +: 2],
    sels: bcsctl2[SELS_BIT]
  };

endmodule

//--- verilog/bcm_clk_pkg.sv
// Basic clock module divider selection and clock configuration types
package bcm_clk_pkg;

  ////////////////////////////////////////
  // Prescaler
  ////////////////////////////////////////

  // Counter width, enough for divide by 8
  localparam int DIV_CW = 3;

  // Divider selection as held in DIVAx / DIVSx
  typedef logic [1:0] div_sel_t;

  // Selection codes
  localparam div_sel_t DIV_1 = 2'd0;
  localparam div_sel_t DIV_2 = 2'd1;
  localparam div_sel_t DIV_4 = 2'd2;
  localparam div_sel_t DIV_8 = 2'd3;

  ////////////////////////////////////////
  // Clock configuration
  ////////////////////////////////////////

  // Decoded register fields used by the clock logic
  // diva  ACLK division
  // divs  SMCLK division
  // sels  SMCLK source, 1 selects the crystal
  typedef struct packed {
    div_sel_t diva;
    div_sel_t divs;
    logic     sels;
  } clk_cfg_t;

endpackage

//--- verilog/bcm_reg_pkg.sv
// Basic clock module register map, peripheral bus request and data word views
package bcm_reg_pkg;

  ////////////////////////////////////////
  // Peripheral bus geometry
  ////////////////////////////////////////

  // Word address width of the peripheral bus
  localparam int PER_AW = 14;

  // Byte base address of the block
  // Aligned to the decoder width
  localparam logic [15:0] BASE_ADDR = 16'h0050;

  // Address bits taken by the local decoder
  localparam int DEC_WD = 4;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Byte offsets from the base
  // Odd offset means high byte lane
  localparam logic [DEC_WD-1:0] BCSCTL1_OFS = 4'h7;
  localparam logic [DEC_WD-1:0] BCSCTL2_OFS = 4'h8;

  // Writable bits, everything else reads zero
  localparam logic [7:0] BCSCTL1_MASK = 8'h30;
  localparam logic [7:0] BCSCTL2_MASK = 8'h0E;

  // Field positions
  localparam int DIVA_LSB = 4;  // BCSCTL1 DIVAx
  localparam int SELS_BIT = 3;  // BCSCTL2 SELS
  localparam int DIVS_LSB = 1;  // BCSCTL2 DIVSx

  ////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////

  // Single-cycle request, we == 0 means read
  typedef struct packed {
    logic              en;
    logic [PER_AW-1:0] addr;
    logic [1:0]        we;
    logic [15:0]       din;
  } per_req_t;

  // Byte lanes of a data word
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } per_bytes_t;

  // Data word seen whole or per byte lane
  typedef union packed {
    logic [15:0] raw;
    per_bytes_t  b;
  } per_word_u;

endpackage
